// File: src/opb_pkg.sv
`default_nettype none

package opb_pkg;

  localparam int OPB_AWIDTH = 32;
  localparam int OPB_DWIDTH = 32;

  // word index of each register, counted from the base address.
  typedef enum logic [2:0] {
    REG_SOFTADDR = 3'd0,
    REG_PHYREADY = 3'd1,
    REG_OVERRIDE = 3'd2,
    REG_ARBSTATE = 3'd3,
    REG_MEMSTATE = 3'd4
  } reg_index_t;

  // bit positions use the big-endian OPB numbering, so bit 31 is the lsb.
  localparam int PHY_READY_BIT = 31;
  localparam int OVR_EN_BIT    = 31;
  localparam int OVR_SEL_BIT   = 24;

endpackage

`default_nettype wire

// File: src/mem_pkg.sv
`default_nettype none

package mem_pkg;

  localparam int CPU_AW     = 8;
  localparam int SOFT_AW    = 16;
  localparam int MEM_ADDR_W = SOFT_AW + CPU_AW;   // 24 bits of command address.
  localparam int MEM_DW     = 32;

  localparam logic SRC_FAB = 1'b0;
  localparam logic SRC_CPU = 1'b1;

  // one memory command as it travels through the fifo.
  typedef struct packed {
    logic [MEM_ADDR_W-1:0] addr;
    logic [MEM_DW-1:0]     wdata;
    logic                  rnw;
    logic                  src;   // 0 is fabric, 1 is cpu.
  } mem_cmd_t;

  typedef enum logic [3:0] {
    INIT   = 4'd0,
    IDLE   = 4'd1,
    ACCESS = 4'd2,
    DONE   = 4'd3
  } dram_state_t;

  typedef enum logic [3:0] {
    NONE      = 4'd0,
    GRANT_FAB = 4'd1,
    GRANT_CPU = 4'd2
  } arb_state_t;

endpackage

`default_nettype wire

// File: src/ctrl_opb_attach.sv
`timescale 1ns/10ps
`default_nettype none

module ctrl_opb_attach #(
  parameter logic [opb_pkg::OPB_AWIDTH-1:0] C_BASEADDR = '0,
  parameter logic [opb_pkg::OPB_AWIDTH-1:0] C_HIGHADDR = '0
) (
  input  logic                            OPB_Clk,
  input  logic                            reset,
  input  logic [0:opb_pkg::OPB_AWIDTH-1]  OPB_ABus,
  input  logic [0:3]                      OPB_BE,
  input  logic [0:opb_pkg::OPB_DWIDTH-1]  OPB_DBus,
  input  logic                            OPB_RNW,
  input  logic                            OPB_select,
  output logic [0:opb_pkg::OPB_DWIDTH-1]  Sl_DBus,
  output logic                            Sl_xferAck,
  output logic                            Sl_errAck,
  input  logic                            phy_ready,
  input  mem_pkg::dram_state_t            dram_state,
  input  logic [3:0]                      fifo_level,
  input  mem_pkg::arb_state_t             arb_state,
  input  logic                            arb_conflict,
  output logic [15:0]                     software_address_bits,
  output logic                            override_en,
  output logic                            override_sel
);

  import opb_pkg::*;

  logic [OPB_AWIDTH-1:0] offset;
  logic                  in_window;
  logic                  mapped;
  logic                  answer;
  reg_index_t            word_idx;
  reg_index_t            rd_idx;   // register index held for the read data phase.
  logic [0:OPB_DWIDTH-1] rd_word;

  assign offset    = OPB_ABus - C_BASEADDR;
  assign in_window = (OPB_ABus >= C_BASEADDR) && (OPB_ABus <= C_HIGHADDR);
  assign word_idx  = reg_index_t'(offset[4:2]);   // byte offset to word index.
  assign mapped    = (offset[OPB_AWIDTH-1:5] == '0) && (offset[4:2] <= 3'(REG_MEMSTATE));

  // only one acknowledge per transfer, never while the previous one is still out.
  assign answer = OPB_select && in_window && !Sl_xferAck && !Sl_errAck;

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      Sl_xferAck            <= 1'b0;
      Sl_errAck             <= 1'b0;
      software_address_bits <= '0;
      override_en           <= 1'b0;
      override_sel          <= 1'b0;
    end else begin
      Sl_xferAck <= answer && mapped;
      Sl_errAck  <= answer && !mapped;
      if (answer && mapped && !OPB_RNW) begin
        case (word_idx)
          REG_SOFTADDR: begin
            if (OPB_BE[3]) software_address_bits[7:0]  <= OPB_DBus[24:31];
            if (OPB_BE[2]) software_address_bits[15:8] <= OPB_DBus[16:23];
          end
          REG_OVERRIDE: begin
            if (OPB_BE[3]) begin
              override_en  <= OPB_DBus[OVR_EN_BIT];
              override_sel <= OPB_DBus[OVR_SEL_BIT];
            end
          end
          default: ;   // status registers ignore writes.
        endcase
      end
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (answer) rd_idx <= word_idx;
  end

  always_comb begin
    rd_word = '0;
    case (rd_idx)
      REG_SOFTADDR: rd_word[16:31]       = software_address_bits;
      REG_PHYREADY: rd_word[PHY_READY_BIT] = phy_ready;
      REG_OVERRIDE: begin
        rd_word[OVR_EN_BIT]  = override_en;
        rd_word[OVR_SEL_BIT] = override_sel;
      end
      REG_ARBSTATE: rd_word[24:31] = {arb_conflict, 3'b000, arb_state};
      REG_MEMSTATE: rd_word[24:31] = {fifo_level, dram_state};
      default:      rd_word = '0;
    endcase
  end

  // the bus sees data only while this slave acknowledges.
  assign Sl_DBus = Sl_xferAck ? rd_word : '0;

endmodule

`default_nettype wire

// File: src/mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
  input  logic                             OPB_Clk,
  input  logic                             reset,
  input  logic                             cpu_req,
  input  logic [mem_pkg::CPU_AW-1:0]       cpu_addr,
  input  logic [mem_pkg::MEM_DW-1:0]       cpu_wdata,
  input  logic                             cpu_rnw,
  output logic                             cpu_ack,
  input  logic                             fab_req,
  input  logic [mem_pkg::MEM_ADDR_W-1:0]   fab_addr,
  input  logic [mem_pkg::MEM_DW-1:0]       fab_wdata,
  input  logic                             fab_rnw,
  output logic                             fab_ack,
  input  logic [mem_pkg::SOFT_AW-1:0]      software_address_bits,
  input  logic                             override_en,
  input  logic                             override_sel,
  input  logic                             full,
  output logic                             push,
  output mem_pkg::mem_cmd_t                push_cmd,
  output mem_pkg::arb_state_t              arb_state,
  output logic                             arb_conflict
);

  import mem_pkg::*;

  logic cpu_ok;
  logic fab_ok;
  logic grant_cpu;
  logic grant_fab;

  // a request whose ack is already out is the one just taken, so skip it.
  assign cpu_ok = cpu_req && !cpu_ack && (!override_en || override_sel);
  assign fab_ok = fab_req && !fab_ack && (!override_en || !override_sel);

  assign grant_cpu = cpu_ok && !full;            // cpu has priority when both ask.
  assign grant_fab = fab_ok && !cpu_ok && !full;
  assign push      = grant_cpu || grant_fab;

  always_comb begin
    if (grant_cpu) begin
      push_cmd.addr  = {software_address_bits, cpu_addr};
      push_cmd.wdata = cpu_wdata;
      push_cmd.rnw   = cpu_rnw;
      push_cmd.src   = SRC_CPU;
    end else begin
      push_cmd.addr  = fab_addr;
      push_cmd.wdata = fab_wdata;
      push_cmd.rnw   = fab_rnw;
      push_cmd.src   = SRC_FAB;
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      cpu_ack      <= 1'b0;
      fab_ack      <= 1'b0;
      arb_state    <= NONE;
      arb_conflict <= 1'b0;
    end else begin
      cpu_ack <= grant_cpu;
      fab_ack <= grant_fab;
      if (grant_cpu) arb_state <= GRANT_CPU;
      else if (grant_fab) arb_state <= GRANT_FAB;
      if (cpu_req && fab_req) arb_conflict <= 1'b1;   // stays set until reset.
    end
  end

endmodule

`default_nettype wire

// File: src/cmd_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic              OPB_Clk,
  input  logic              reset,
  input  logic              push,
  input  mem_pkg::mem_cmd_t push_cmd,
  input  logic              pop,
  output mem_pkg::mem_cmd_t head_cmd,
  output logic              full,
  output logic              empty,
  output logic [3:0]        level
);

  import mem_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  mem_cmd_t         slots [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full     = (level == 4'(FIFO_DEPTH));
  assign empty    = (level == 4'd0);
  assign do_push  = push && !full;   // overflow and underflow are dropped.
  assign do_pop   = pop && !empty;
  assign head_cmd = slots[rd_ptr];

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= 4'd0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   level <= level + 4'd1;
        2'b01:   level <= level - 4'd1;
        default: level <= level;
      endcase
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (do_push) slots[wr_ptr] <= push_cmd;
  end

endmodule

`default_nettype wire

// File: src/dram_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module dram_sequencer #(
  parameter int INIT_CYCLES   = 16,
  parameter int ACCESS_CYCLES = 3,
  parameter int MEM_AW        = 10
) (
  input  logic                       OPB_Clk,
  input  logic                       reset,
  input  logic                       empty,
  input  mem_pkg::mem_cmd_t          head_cmd,
  output logic                       pop,
  output logic                       phy_ready,
  output mem_pkg::dram_state_t       dram_state,
  output logic                       rd_valid,
  output logic [mem_pkg::MEM_DW-1:0] rd_data,
  output logic                       rd_src
);

  import mem_pkg::*;

  localparam int MAX_CNT = (INIT_CYCLES > ACCESS_CYCLES) ? INIT_CYCLES : ACCESS_CYCLES;
  localparam int CNT_W   = $clog2(MAX_CNT + 1);

  logic [MEM_DW-1:0] mem [2**MEM_AW];   // behavioural stand-in for the dram.
  logic [CNT_W-1:0]  cnt;               // shared by init and access timing.
  mem_cmd_t          cur_cmd;
  logic [MEM_AW-1:0] word_idx;

  initial begin
    for (int i = 0; i < 2**MEM_AW; i++) begin
      mem[i] = '0;
    end
  end

  assign phy_ready = (dram_state != INIT);
  assign pop       = (dram_state == IDLE) && !empty;
  assign word_idx  = cur_cmd.addr[MEM_AW-1:0];

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      dram_state <= INIT;
      cnt        <= '0;
      rd_valid   <= 1'b0;
    end else begin
      rd_valid <= 1'b0;
      case (dram_state)
        INIT: begin
          if (cnt == CNT_W'(INIT_CYCLES - 1)) begin
            dram_state <= IDLE;   // phy is ready from here on.
            cnt        <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        IDLE: begin
          if (pop) dram_state <= ACCESS;
        end
        ACCESS: begin
          if (cnt == CNT_W'(ACCESS_CYCLES - 1)) begin
            dram_state <= DONE;
            cnt        <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        DONE: begin
          dram_state <= IDLE;
          rd_valid   <= cur_cmd.rnw;
        end
        default: dram_state <= INIT;
      endcase
    end
  end

  // the array itself is touched only in the last cycle of a command.
  always_ff @(posedge OPB_Clk) begin
    if (pop) cur_cmd <= head_cmd;
    if (dram_state == DONE) begin
      if (cur_cmd.rnw) begin
        rd_data <= mem[word_idx];
        rd_src  <= cur_cmd.src;
      end else begin
        mem[word_idx] <= cur_cmd.wdata;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/mem_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_ctrl_top #(
  parameter logic [opb_pkg::OPB_AWIDTH-1:0] C_BASEADDR    = 32'h8000_0000,
  parameter logic [opb_pkg::OPB_AWIDTH-1:0] C_HIGHADDR    = 32'h8000_00FF,
  parameter int                             FIFO_DEPTH    = 8,
  parameter int                             INIT_CYCLES   = 16,
  parameter int                             ACCESS_CYCLES = 3,
  parameter int                             MEM_AW        = 10
) (
  input  logic                            OPB_Clk,
  input  logic                            reset,
  input  logic [0:opb_pkg::OPB_AWIDTH-1]  OPB_ABus,
  input  logic [0:3]                      OPB_BE,
  input  logic [0:opb_pkg::OPB_DWIDTH-1]  OPB_DBus,
  input  logic                            OPB_RNW,
  input  logic                            OPB_select,
  output logic [0:opb_pkg::OPB_DWIDTH-1]  Sl_DBus,
  output logic                            Sl_xferAck,
  output logic                            Sl_errAck,
  input  logic                            cpu_req,
  input  logic [mem_pkg::CPU_AW-1:0]      cpu_addr,
  input  logic [mem_pkg::MEM_DW-1:0]      cpu_wdata,
  input  logic                            cpu_rnw,
  output logic                            cpu_ack,
  input  logic                            fab_req,
  input  logic [mem_pkg::MEM_ADDR_W-1:0]  fab_addr,
  input  logic [mem_pkg::MEM_DW-1:0]      fab_wdata,
  input  logic                            fab_rnw,
  output logic                            fab_ack,
  output logic                            rd_valid,
  output logic [mem_pkg::MEM_DW-1:0]      rd_data,
  output logic                            rd_src
);

  import mem_pkg::*;

  logic [SOFT_AW-1:0] software_address_bits;
  logic               override_en;
  logic               override_sel;
  logic               phy_ready;
  dram_state_t        dram_state;
  logic [3:0]         fifo_level;
  arb_state_t         arb_state;
  logic               arb_conflict;
  logic               push;
  mem_cmd_t           push_cmd;
  logic               pop;
  mem_cmd_t           head_cmd;
  logic               full;
  logic               empty;

  ctrl_opb_attach #(
    .C_BASEADDR(C_BASEADDR),
    .C_HIGHADDR(C_HIGHADDR)
  ) ctrl_opb_attach_i (
    .OPB_Clk(OPB_Clk), .reset(reset),
    .OPB_ABus(OPB_ABus), .OPB_BE(OPB_BE), .OPB_DBus(OPB_DBus),
    .OPB_RNW(OPB_RNW), .OPB_select(OPB_select),
    .Sl_DBus(Sl_DBus), .Sl_xferAck(Sl_xferAck), .Sl_errAck(Sl_errAck),
    .phy_ready(phy_ready), .dram_state(dram_state), .fifo_level(fifo_level),
    .arb_state(arb_state), .arb_conflict(arb_conflict),
    .software_address_bits(software_address_bits),
    .override_en(override_en), .override_sel(override_sel)
  );

  mem_arbiter mem_arbiter_i (
    .OPB_Clk(OPB_Clk), .reset(reset),
    .cpu_req(cpu_req), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
    .cpu_rnw(cpu_rnw), .cpu_ack(cpu_ack),
    .fab_req(fab_req), .fab_addr(fab_addr), .fab_wdata(fab_wdata),
    .fab_rnw(fab_rnw), .fab_ack(fab_ack),
    .software_address_bits(software_address_bits),
    .override_en(override_en), .override_sel(override_sel),
    .full(full), .push(push), .push_cmd(push_cmd),
    .arb_state(arb_state), .arb_conflict(arb_conflict)
  );

  cmd_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) cmd_fifo_i (
    .OPB_Clk(OPB_Clk), .reset(reset),
    .push(push), .push_cmd(push_cmd), .pop(pop),
    .head_cmd(head_cmd), .full(full), .empty(empty), .level(fifo_level)
  );

  dram_sequencer #(
    .INIT_CYCLES(INIT_CYCLES),
    .ACCESS_CYCLES(ACCESS_CYCLES),
    .MEM_AW(MEM_AW)
  ) dram_sequencer_i (
    .OPB_Clk(OPB_Clk), .reset(reset),
    .empty(empty), .head_cmd(head_cmd), .pop(pop),
    .phy_ready(phy_ready), .dram_state(dram_state),
    .rd_valid(rd_valid), .rd_data(rd_data), .rd_src(rd_src)
  );

endmodule

`default_nettype wire

// File: verification/clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clk_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // reset falls just after a rising edge, like every other driven input.
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 reset = 1'b0;
  end

endmodule

`default_nettype wire

// File: verification/tb_mem_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_ctrl;

  import opb_pkg::*;
  import mem_pkg::*;

  localparam logic [OPB_AWIDTH-1:0] BASE_ADDR = 32'h8000_0000;
  localparam int FIFO_DEPTH    = 8;
  localparam int INIT_CYCLES   = 16;
  localparam int ACCESS_CYCLES = 3;
  localparam int MEM_AW        = 10;
  localparam int N_RAND        = 12;
  localparam int N_BURST       = 32;
  localparam int ACK_LIMIT     = 100;
  localparam int MAX_CYCLES    = 4000;   // about twice what the six tests need.

  logic                  OPB_Clk;
  logic                  reset;
  logic [0:OPB_AWIDTH-1] OPB_ABus;
  logic [0:3]            OPB_BE;
  logic [0:OPB_DWIDTH-1] OPB_DBus;
  logic                  OPB_RNW;
  logic                  OPB_select;
  logic [0:OPB_DWIDTH-1] Sl_DBus;
  logic                  Sl_xferAck;
  logic                  Sl_errAck;
  logic                  cpu_req;
  logic [CPU_AW-1:0]     cpu_addr;
  logic [MEM_DW-1:0]     cpu_wdata;
  logic                  cpu_rnw;
  logic                  cpu_ack;
  logic                  fab_req;
  logic [MEM_ADDR_W-1:0] fab_addr;
  logic [MEM_DW-1:0]     fab_wdata;
  logic                  fab_rnw;
  logic                  fab_ack;
  logic                  rd_valid;
  logic [MEM_DW-1:0]     rd_data;
  logic                  rd_src;

  // reference state, updated as the DUT accepts each command or register write.
  logic [MEM_DW-1:0]     model_mem [2**MEM_AW];
  logic [SOFT_AW-1:0]    model_soft;
  logic                  model_phy;
  logic                  model_ovr_en;
  logic                  model_ovr_sel;
  logic                  model_conflict;
  arb_state_t            model_arb;

  logic [0:OPB_DWIDTH-1] opb_exp [$];
  logic [0:OPB_DWIDTH-1] opb_mask [$];
  logic [MEM_DW-1:0]     rd_exp_data [$];
  logic                  rd_exp_src [$];

  int                    cyc;
  int                    errors;
  int                    checks;
  int                    err_mark;
  int                    tests;
  int                    failed;
  int                    t_cpu;
  int                    t_fab;
  logic                  early_ack;
  logic [OPB_DWIDTH-1:0] rd;
  logic                  err;
  logic [MEM_ADDR_W-1:0] a_cpu [N_RAND];
  logic [MEM_ADDR_W-1:0] a_fab [N_RAND];

  clk_gen #(.PERIOD(40), .RESET_CYCLES(5)) clk_gen_i (.clk(OPB_Clk), .reset(reset));

  mem_ctrl_top #(
    .C_BASEADDR(BASE_ADDR),
    .C_HIGHADDR(BASE_ADDR + 32'h0000_00FF),
    .FIFO_DEPTH(FIFO_DEPTH),
    .INIT_CYCLES(INIT_CYCLES),
    .ACCESS_CYCLES(ACCESS_CYCLES),
    .MEM_AW(MEM_AW)
  ) mem_ctrl_top_i (
    .OPB_Clk(OPB_Clk), .reset(reset),
    .OPB_ABus(OPB_ABus), .OPB_BE(OPB_BE), .OPB_DBus(OPB_DBus),
    .OPB_RNW(OPB_RNW), .OPB_select(OPB_select),
    .Sl_DBus(Sl_DBus), .Sl_xferAck(Sl_xferAck), .Sl_errAck(Sl_errAck),
    .cpu_req(cpu_req), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
    .cpu_rnw(cpu_rnw), .cpu_ack(cpu_ack),
    .fab_req(fab_req), .fab_addr(fab_addr), .fab_wdata(fab_wdata),
    .fab_rnw(fab_rnw), .fab_ack(fab_ack),
    .rd_valid(rd_valid), .rd_data(rd_data), .rd_src(rd_src)
  );

  // register value as software should see it, in plain numeric bit order.
  function automatic logic [OPB_DWIDTH-1:0] reg_expect(input reg_index_t idx);
    logic [OPB_DWIDTH-1:0] v;
    v = '0;
    case (idx)
      REG_SOFTADDR: v[15:0] = model_soft;
      REG_PHYREADY: v[OPB_DWIDTH-1-PHY_READY_BIT] = model_phy;
      REG_OVERRIDE: begin
        v[OPB_DWIDTH-1-OVR_EN_BIT]  = model_ovr_en;
        v[OPB_DWIDTH-1-OVR_SEL_BIT] = model_ovr_sel;
      end
      REG_ARBSTATE: v[7:0] = {model_conflict, 3'b000, model_arb};
      default: v = '0;   // memory status fields move, so only its unused bits are compared.
    endcase
    return v;
  endfunction

  function automatic logic [MEM_ADDR_W-1:0] cmd_addr(input logic src,
                                                     input logic [MEM_ADDR_W-1:0] addr);
    return (src == SRC_CPU) ? {model_soft, addr[CPU_AW-1:0]} : addr;
  endfunction

  function automatic logic [MEM_DW-1:0] expect_read(input logic [MEM_ADDR_W-1:0] addr);
    return model_mem[addr[MEM_AW-1:0]];
  endfunction

  function automatic void accept(input logic src, input logic rnw,
                                 input logic [MEM_ADDR_W-1:0] addr,
                                 input logic [MEM_DW-1:0] data);
    model_arb = (src == SRC_CPU) ? GRANT_CPU : GRANT_FAB;
    if (rnw) begin
      rd_exp_data.push_back(expect_read(addr));
      rd_exp_src.push_back(src);
    end else begin
      model_mem[addr[MEM_AW-1:0]] = data;
    end
  endfunction

  task automatic check_word(input logic [0:OPB_DWIDTH-1] got, input logic [0:OPB_DWIDTH-1] exp,
                            input logic [0:OPB_DWIDTH-1] mask);
    checks++;
    if ((got & mask) !== (exp & mask)) begin
      errors++;
      $display("mismatch at %0t: register read %h, expected %h", $time, got & mask, exp & mask);
    end
  endtask

  task automatic check_read(input logic [MEM_DW-1:0] got, input logic got_src,
                            input logic [MEM_DW-1:0] exp, input logic exp_src);
    checks++;
    if (got !== exp || got_src !== exp_src) begin
      errors++;
      $display("mismatch at %0t: read data %h from src %b, expected %h from src %b",
               $time, got, got_src, exp, exp_src);
    end
  endtask

  task automatic opb_xfer(input logic rnw, input logic [OPB_AWIDTH-1:0] offset,
                          input logic [0:3] be, input logic [OPB_DWIDTH-1:0] wdata,
                          output logic [OPB_DWIDTH-1:0] rdata, output logic err_seen);
    int waited;
    @(posedge OPB_Clk);
    #2;
    OPB_ABus   = BASE_ADDR + offset;
    OPB_BE     = be;
    OPB_DBus   = rnw ? '0 : wdata;
    OPB_RNW    = rnw;
    OPB_select = 1'b1;
    waited = 0;
    do begin
      @(negedge OPB_Clk);
      waited++;
    end while (!Sl_xferAck && !Sl_errAck && waited < 16);
    if (!Sl_xferAck && !Sl_errAck) begin
      errors++;
      $display("OPB slave never acknowledged the transfer at offset %h", offset);
    end
    rdata    = Sl_DBus;
    err_seen = Sl_errAck;
    @(posedge OPB_Clk);
    #2;
    OPB_select = 1'b0;   // the master lets go once it has seen the acknowledge.
    OPB_RNW    = 1'b1;
    OPB_DBus   = '0;
  endtask

  task automatic opb_read_reg(input reg_index_t idx, input logic [OPB_DWIDTH-1:0] mask,
                              output logic [OPB_DWIDTH-1:0] rdata);
    logic e;
    opb_exp.push_back(reg_expect(idx));
    opb_mask.push_back(mask);
    opb_xfer(1'b1, {27'd0, idx, 2'b00}, 4'b1111, '0, rdata, e);
    if (e) begin
      errors++;
      $display("register %0d answered a read with an error acknowledge", idx);
    end
  endtask

  task automatic opb_write_reg(input reg_index_t idx, input logic [0:3] be,
                               input logic [OPB_DWIDTH-1:0] data);
    logic [OPB_DWIDTH-1:0] unused;
    logic e;
    opb_xfer(1'b0, {27'd0, idx, 2'b00}, be, data, unused, e);
    if (idx == REG_SOFTADDR && be[3]) model_soft[7:0] = data[7:0];
    if (idx == REG_SOFTADDR && be[2]) model_soft[15:8] = data[15:8];
    if (idx == REG_OVERRIDE && be[3]) begin
      model_ovr_en  = data[OPB_DWIDTH-1-OVR_EN_BIT];
      model_ovr_sel = data[OPB_DWIDTH-1-OVR_SEL_BIT];
    end
  endtask

  // one requester command, held until its ack pulse.
  task automatic mem_access(input logic src, input logic rnw, input logic [MEM_ADDR_W-1:0] addr,
                            input logic [MEM_DW-1:0] data, output int ack_cyc);
    int   waited;
    logic acked;
    @(posedge OPB_Clk);
    #2;
    if (src == SRC_CPU) begin
      cpu_addr  = addr[CPU_AW-1:0];
      cpu_wdata = data;
      cpu_rnw   = rnw;
      cpu_req   = 1'b1;
    end else begin
      fab_addr  = addr;
      fab_wdata = data;
      fab_rnw   = rnw;
      fab_req   = 1'b1;
    end
    waited = 0;
    acked  = 1'b0;
    while (!acked && waited < ACK_LIMIT) begin
      @(negedge OPB_Clk);
      waited++;
      acked = (src == SRC_CPU) ? cpu_ack : fab_ack;
    end
    ack_cyc = cyc;
    if (acked) begin
      accept(src, rnw, cmd_addr(src, addr), data);
    end else begin
      errors++;
      $display("%s request to %h was never acknowledged", src ? "cpu" : "fabric", addr);
    end
    @(posedge OPB_Clk);
    #2;
    if (src == SRC_CPU) cpu_req = 1'b0;
    else fab_req = 1'b0;
  endtask

  task automatic wait_reads();
    int waited;
    waited = 0;
    while (rd_exp_data.size() != 0 && waited < 400) begin
      @(negedge OPB_Clk);
      waited++;
    end
    if (rd_exp_data.size() != 0) begin
      errors++;
      $display("%0d read results never came back", rd_exp_data.size());
      rd_exp_data.delete();
      rd_exp_src.delete();
    end
  endtask

  task automatic report_test(input string name);
    tests++;
    if (errors == err_mark) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      failed++;
      $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  // compare every register read and every read return against the model.
  always @(negedge OPB_Clk) begin
    if (!reset && Sl_xferAck && OPB_RNW) begin
      if (opb_exp.size() == 0) begin
        errors++;
        $display("register read acknowledged at %0t with no read outstanding", $time);
      end else begin
        check_word(Sl_DBus, opb_exp.pop_front(), opb_mask.pop_front());
      end
    end
    if (!reset && rd_valid) begin
      if (rd_exp_data.size() == 0) begin
        errors++;
        $display("read data returned at %0t with no read outstanding", $time);
      end else begin
        check_read(rd_data, rd_src, rd_exp_data.pop_front(), rd_exp_src.pop_front());
      end
    end
  end

  always @(posedge OPB_Clk) begin
    cyc = cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    OPB_ABus   = '0;
    OPB_BE     = '0;
    OPB_DBus   = '0;
    OPB_RNW    = 1'b1;
    OPB_select = 1'b0;
    cpu_req    = 1'b0;
    cpu_addr   = '0;
    cpu_wdata  = '0;
    cpu_rnw    = 1'b0;
    fab_req    = 1'b0;
    fab_addr   = '0;
    fab_wdata  = '0;
    fab_rnw    = 1'b0;
    for (int i = 0; i < 2**MEM_AW; i++) model_mem[i] = '0;
    model_soft     = '0;
    model_phy      = 1'b0;
    model_ovr_en   = 1'b0;
    model_ovr_sel  = 1'b0;
    model_conflict = 1'b0;
    model_arb      = NONE;
    void'($urandom(47964));
    wait (reset === 1'b0);

    opb_read_reg(REG_PHYREADY, '1, rd);   // still initialising here.
    repeat (INIT_CYCLES + 2) @(posedge OPB_Clk);
    model_phy = 1'b1;
    opb_read_reg(REG_PHYREADY, '1, rd);
    opb_read_reg(REG_SOFTADDR, '1, rd);
    opb_read_reg(REG_OVERRIDE, '1, rd);
    report_test("reset values");

    opb_write_reg(REG_SOFTADDR, 4'b0001, 32'hFFFF_12A5);
    opb_read_reg(REG_SOFTADDR, '1, rd);
    opb_write_reg(REG_SOFTADDR, 4'b0010, 32'hFFFF_3C00);
    opb_read_reg(REG_SOFTADDR, '1, rd);
    opb_write_reg(REG_SOFTADDR, 4'b1100, 32'h7777_7777);
    opb_read_reg(REG_SOFTADDR, '1, rd);
    opb_write_reg(REG_OVERRIDE, 4'b0001, 32'h0000_0081);
    opb_read_reg(REG_OVERRIDE, '1, rd);
    opb_write_reg(REG_OVERRIDE, 4'b0001, 32'h0000_0000);
    opb_read_reg(REG_OVERRIDE, '1, rd);
    opb_xfer(1'b0, 32'h0000_0014, 4'b1111, 32'h1, rd, err);
    if (!err) begin
      errors++;
      $display("write to an unmapped offset gave no error acknowledge");
    end
    opb_xfer(1'b1, 32'h0000_0040, 4'b1111, '0, rd, err);
    if (!err) begin
      errors++;
      $display("read from an unmapped offset gave no error acknowledge");
    end
    report_test("register access");

    for (int i = 0; i < N_RAND; i++) begin
      a_cpu[i] = {16'h0000, 8'($urandom)};
      a_fab[i] = 24'($urandom);
      mem_access(SRC_CPU, 1'b0, a_cpu[i], $urandom, t_cpu);
      mem_access(SRC_FAB, 1'b0, a_fab[i], $urandom, t_fab);
    end
    for (int i = 0; i < N_RAND; i++) begin
      mem_access(SRC_CPU, 1'b1, a_cpu[i], '0, t_cpu);
      mem_access(SRC_FAB, 1'b1, a_fab[i], '0, t_fab);
    end
    wait_reads();
    report_test("random writes and reads");

    opb_write_reg(REG_SOFTADDR, 4'b0011, 32'h0000_0002);
    mem_access(SRC_CPU, 1'b0, 24'h00005A, $urandom, t_cpu);
    opb_write_reg(REG_SOFTADDR, 4'b0011, 32'h0000_0003);
    mem_access(SRC_CPU, 1'b0, 24'h00005A, $urandom, t_cpu);
    mem_access(SRC_CPU, 1'b1, 24'h00005A, '0, t_cpu);
    mem_access(SRC_FAB, 1'b1, 24'h00025A, '0, t_fab);
    mem_access(SRC_FAB, 1'b1, 24'h00035A, '0, t_fab);
    wait_reads();
    report_test("software address bits");

    model_conflict = 1'b1;   // both requests are raised on the same edge.
    fork
      mem_access(SRC_CPU, 1'b0, 24'h000021, 32'hC0DE_0001, t_cpu);
      mem_access(SRC_FAB, 1'b0, 24'h000321, 32'hFAB0_0001, t_fab);
    join
    if (t_cpu >= t_fab) begin
      errors++;
      $display("mismatch at %0t: fabric was granted before the cpu", $time);
    end
    opb_read_reg(REG_ARBSTATE, '1, rd);
    opb_write_reg(REG_OVERRIDE, 4'b0001, 32'h0000_0001);
    early_ack = 1'b0;
    fork
      mem_access(SRC_CPU, 1'b1, 24'h000021, '0, t_cpu);
      begin
        repeat (20) begin
          @(negedge OPB_Clk);
          if (cpu_ack) early_ack = 1'b1;
        end
        opb_write_reg(REG_OVERRIDE, 4'b0001, 32'h0000_0000);
      end
    join
    if (early_ack) begin
      errors++;
      $display("cpu request was acknowledged while the override selected the fabric");
    end
    wait_reads();
    report_test("arbitration and override");

    fork
      for (int i = 0; i < N_BURST; i++) begin
        mem_access(SRC_FAB, 1'b0, 24'h000200 + 24'(i), $urandom, t_fab);
      end
      begin
        repeat (40) @(posedge OPB_Clk);
        opb_read_reg(REG_MEMSTATE, 32'hFFFF_FF00, rd);
        if (rd[7:4] > 4'(FIFO_DEPTH)) begin
          errors++;
          $display("mismatch at %0t: fifo level %0d above depth", $time, rd[7:4]);
        end
      end
    join
    for (int i = 0; i < N_BURST; i++) begin
      mem_access(SRC_FAB, 1'b1, 24'h000200 + 24'(i), '0, t_fab);
    end
    wait_reads();
    report_test("fabric burst");

    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
src/opb_pkg.sv
src/mem_pkg.sv
src/ctrl_opb_attach.sv
src/mem_arbiter.sv
src/cmd_fifo.sv
src/dram_sequencer.sv
src/mem_ctrl_top.sv
verification/clk_gen.sv
verification/tb_mem_ctrl.sv

// File: Makefile
TOP = tb_mem_ctrl

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/10ps --top-module $(TOP) -f src.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
